// ==== hw/cycle_ctl.sv ====
// start, stop and cycle start control
`timescale 1ns/1ps

module cycle_ctl (
	input logic __clk,
	input logic arst_n,
	input logic start,
	input logic stop,
	input logic irq,
	input logic cycle_done,
	input logic halt_req,
	output logic run,
	output logic cycle_go,
	output logic take_irq
);

	logic stop_pend;
	logic in_cycle;
	logic go_ok;
	logic run_clr;

	// new cycle may begin only when idle and no start is already issued
	assign go_ok = run && !in_cycle && !cycle_go;

	// stop or halt takes effect at cycle end only
	assign run_clr = cycle_done && (stop_pend || stop || halt_req);

	// run flip-flop
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
		end else if (start) begin
			run <= 1'b1;
		end else if (run_clr) begin
			run <= 1'b0;
		end
	end

	// remember a stop until the current cycle ends
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			stop_pend <= 1'b0;
		end else if (cycle_done) begin
			stop_pend <= 1'b0;
		end else if (stop) begin
			stop_pend <= 1'b1;
		end
	end

	// cycle start and fetch-or-interrupt choice
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			cycle_go <= 1'b0;
			take_irq <= 1'b0;
			in_cycle <= 1'b0;
		end else begin
			cycle_go <= go_ok;
			// irq sampled on the edge that raises cycle_go
			if (go_ok) begin
				take_irq <= irq;
			end
			if (cycle_go) begin
				in_cycle <= 1'b1;
			end else if (cycle_done) begin
				in_cycle <= 1'b0;
			end
		end
	end

	// a new cycle never overlaps one still running in the sequencer
	a_go_idle: assert property (
		@(posedge __clk) disable iff (!arst_n)
		cycle_go |-> !in_cycle && !cycle_done
	);

endmodule

// ==== hw/group_counter.sv ====
// register group counter
`timescale 1ns/1ps

module group_counter (
	input logic __clk,
	input logic arst_n,
	input pm_pkg::reg_addr_t reg_a_field,
	seq_if.cnt ctl
);
	import pm_pkg::*;

	reg_addr_t lg;

	// load wins over step
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			lg <= '0;
		end else if (ctl.lg_load) begin
			lg <= reg_a_field;
		end else if (ctl.lg_step) begin
			lg <= lg + reg_addr_t'(1);
		end
	end

	assign ctl.lg_value = lg;
	assign ctl.lg_last = (lg == reg_last);

	// sequencer must stop stepping once the top register is reached
	a_no_step_past_last: assert property (
		@(posedge __clk) disable iff (!arst_n)
		ctl.lg_last |-> !ctl.lg_step
	);

endmodule

// ==== hw/ir_decode.sv ====
// instruction register and selector decode
`timescale 1ns/1ps

module ir_decode (
	input logic __clk,
	input logic arst_n,
	input pm_pkg::word_t ir,
	input logic ir_ok,
	input pm_pkg::phase_t phase,
	input pm_pkg::reg_addr_t lg_value,
	output pm_pkg::op_class_t op_class,
	output pm_pkg::reg_addr_t reg_a_field,
	output pm_pkg::reg_addr_t reg_a,
	output pm_pkg::reg_addr_t reg_b,
	output pm_pkg::step_t shift_count
);
	import pm_pkg::*;

	word_t ir_q;

	// ir captured only while waiting in the fetch phase
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			ir_q <= '0;
		end else if (ir_ok && (phase == p1)) begin
			ir_q <= ir;
		end
	end

	// field extraction
	assign op_class = op_class_t'(ir_q[op_hi:op_lo]);
	assign reg_a_field = ir_q[ra_hi:ra_lo];
	assign reg_b = ir_q[rb_hi:rb_lo];
	assign shift_count = ir_q[cnt_hi:cnt_lo];

	// reg_a source
	always_comb begin
		if (phase == p1) begin
			// interrupt receive writes the fixed vector register
			reg_a = intr_vector;
		end else if ((phase == p4) && (op_class == op_group)) begin
			reg_a = lg_value;
		end else begin
			reg_a = reg_a_field;
		end
	end

endmodule

// ==== hw/phase_seq.sv ====
// instruction phase sequencer
`timescale 1ns/1ps

module phase_seq (
	input logic __clk,
	input logic arst_n,
	input logic cycle_go,
	input logic take_irq,
	input logic ir_ok,
	input pm_pkg::op_class_t op_class,
	seq_if.seq ctl,
	output logic fetch,
	output logic intr_ack,
	output logic w_reg,
	output logic shift_step,
	output logic cycle_done,
	output logic halt_req,
	output pm_pkg::phase_t phase
);
	import pm_pkg::*;

	phase_t phase_nxt;
	logic grp_run;
	logic shf_run;
	logic loop_end;

	// execute loop qualifiers
	assign grp_run = (phase == p4) && (op_class == op_group);
	assign shf_run = (phase == p4) && (op_class == op_shift);
	assign loop_end = (grp_run && ctl.lg_last) || (shf_run && ctl.lk_zero);

	// next phase
	always_comb begin
		phase_nxt = phase;
		case (phase)
			p0: begin
				if (cycle_go) begin
					phase_nxt = p1;
				end
			end
			p1: begin
				// interrupt receive is a single p1 cycle
				if (intr_ack) begin
					phase_nxt = p5;
				end else if (ir_ok) begin
					phase_nxt = p2;
				end
			end
			p2: begin
				case (op_class)
					op_move: phase_nxt = p3;
					op_group: phase_nxt = p4;
					op_shift: phase_nxt = p4;
					op_halt: phase_nxt = p5;
					default: phase_nxt = p5;
				endcase
			end
			p3: phase_nxt = p5;
			p4: begin
				if (loop_end) begin
					phase_nxt = p5;
				end
			end
			p5: phase_nxt = p0;
			default: phase_nxt = p0;
		endcase
	end

	// phase register and registered strobes
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= p0;
			fetch <= 1'b0;
			intr_ack <= 1'b0;
			halt_req <= 1'b0;
		end else begin
			phase <= phase_nxt;
			fetch <= cycle_go && !take_irq;
			intr_ack <= cycle_go && take_irq;
			// lines up with cycle_done in p5
			halt_req <= (phase == p2) && (op_class == op_halt);
		end
	end

	assign w_reg = (phase == p3) || grp_run;
	assign shift_step = shf_run && !ctl.lk_zero;
	assign cycle_done = (phase == p5);

	// counters load in decode, step through the loop
	assign ctl.lg_load = (phase == p2);
	assign ctl.lk_load = (phase == p2);
	assign ctl.lg_step = grp_run && !ctl.lg_last;
	assign ctl.lk_step = shift_step;

	// a cycle start finds the sequencer idle, then gives a fetch or an interrupt receive
	a_fetch_or_ack: assert property (
		@(posedge __clk) disable iff (!arst_n)
		cycle_go |-> (phase == p0) ##1 ((phase == p1) && (fetch ^ intr_ack))
	);

endmodule

// ==== hw/pm.sv ====
// P-M instruction cycle control unit
`timescale 1ns/1ps

module pm (
	input logic __clk,
	input logic arst_n,
	input logic start,
	input logic stop,
	input logic irq,
	input pm_pkg::word_t ir,
	input logic ir_ok,
	output logic run,
	output logic fetch,
	output logic intr_ack,
	output logic w_reg,
	output pm_pkg::reg_addr_t reg_a,
	output pm_pkg::reg_addr_t reg_b,
	output logic shift_step,
	output logic cycle_end
);
	import pm_pkg::*;

	logic cycle_go;
	logic take_irq;
	logic halt_req;
	op_class_t op_class;
	phase_t phase;
	reg_addr_t reg_a_field;
	step_t shift_count;

	seq_if i_seq_if ();

	cycle_ctl i_cycle_ctl (
		.__clk(__clk),
		.arst_n(arst_n),
		.start(start),
		.stop(stop),
		.irq(irq),
		.cycle_done(cycle_end),
		.halt_req(halt_req),
		.run(run),
		.cycle_go(cycle_go),
		.take_irq(take_irq)
	);

	phase_seq i_phase_seq (
		.__clk(__clk),
		.arst_n(arst_n),
		.cycle_go(cycle_go),
		.take_irq(take_irq),
		.ir_ok(ir_ok),
		.op_class(op_class),
		.ctl(i_seq_if.seq),
		.fetch(fetch),
		.intr_ack(intr_ack),
		.w_reg(w_reg),
		.shift_step(shift_step),
		.cycle_done(cycle_end),
		.halt_req(halt_req),
		.phase(phase)
	);

	ir_decode i_ir_decode (
		.__clk(__clk),
		.arst_n(arst_n),
		.ir(ir),
		.ir_ok(ir_ok),
		.phase(phase),
		.lg_value(i_seq_if.lg_value),
		.op_class(op_class),
		.reg_a_field(reg_a_field),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.shift_count(shift_count)
	);

	group_counter i_group_counter (
		.__clk(__clk),
		.arst_n(arst_n),
		.reg_a_field(reg_a_field),
		.ctl(i_seq_if.cnt)
	);

	step_counter i_step_counter (
		.__clk(__clk),
		.arst_n(arst_n),
		.shift_count(shift_count),
		.ctl(i_seq_if.cnt)
	);

endmodule

// ==== hw/pm_pkg.sv ====
// P-M control unit definitions
package pm_pkg;

	// datapath widths
	localparam int word_w = 16;
	localparam int reg_w = 3;
	localparam int step_w = 4;

	// instruction word and its pieces
	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_w-1:0] reg_addr_t;
	typedef logic [step_w-1:0] step_t;

	// instruction field positions
	// opcode class sits in the two top bits
	localparam int op_hi = 15;
	localparam int op_lo = 14;
	localparam int ra_hi = 13;
	localparam int ra_lo = 11;
	localparam int rb_hi = 10;
	localparam int rb_lo = 8;
	// shift count in the low nibble
	localparam int cnt_hi = 3;
	localparam int cnt_lo = 0;

	// instruction classes
	typedef enum logic [1:0] {
		op_move = 2'b00,
		op_group = 2'b01,
		op_shift = 2'b10,
		op_halt = 2'b11
	} op_class_t;

	// instruction cycle phases
	typedef enum logic [2:0] {
		// idle, waiting for a cycle start
		p0 = 3'd0,
		// fetch wait or interrupt receive
		p1 = 3'd1,
		// decode
		p2 = 3'd2,
		// single register write
		p3 = 3'd3,
		// group or shift loop
		p4 = 3'd4,
		// cycle end
		p5 = 3'd5
	} phase_t;

	// selector shown on reg_a during interrupt receive
	localparam reg_addr_t intr_vector = 3'd7;

	// top register of a group transfer
	localparam reg_addr_t reg_last = 3'd7;

endpackage

// ==== hw/seq_if.sv ====
// sequencer to counter link
`timescale 1ns/1ps

interface seq_if;
	import pm_pkg::*;

	// group counter control
	logic lg_load;
	logic lg_step;

	// step counter control
	logic lk_load;
	logic lk_step;

	// counter status, valid the cycle after a load
	reg_addr_t lg_value;
	logic lg_last;
	logic lk_zero;

	modport seq (
		output lg_load, lg_step, lk_load, lk_step,
		input lg_last, lk_zero
	);

	modport cnt (
		input lg_load, lg_step, lk_load, lk_step,
		output lg_value, lg_last, lk_zero
	);

endinterface

// ==== hw/step_counter.sv ====
// shift step counter
`timescale 1ns/1ps

module step_counter (
	input logic __clk,
	input logic arst_n,
	input pm_pkg::step_t shift_count,
	seq_if.cnt ctl
);
	import pm_pkg::*;

	step_t lk;

	// counts down to zero, load wins over step
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			lk <= '0;
		end else if (ctl.lk_load) begin
			lk <= shift_count;
		end else if (ctl.lk_step) begin
			lk <= lk - step_t'(1);
		end
	end

	assign ctl.lk_zero = (lk == '0);

	// no wrap below zero
	a_no_step_at_zero: assert property (
		@(posedge __clk) disable iff (!arst_n)
		ctl.lk_step |-> !ctl.lk_zero
	);

endmodule

// ==== pm.f ====
+incdir+tests
hw/pm_pkg.sv
hw/seq_if.sv
hw/cycle_ctl.sv
hw/phase_seq.sv
hw/ir_decode.sv
hw/group_counter.sv
hw/step_counter.sv
hw/pm.sv
tests/pm_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pm testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f pm.f --top-module pm_tb -o pm_tb_sim
out=$(./obj_dir/pm_tb_sim)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"

// ==== tests/pm_cases.svh ====
// instruction cycle test table

typedef struct packed {
	logic irq;
	word_t ir;
	logic stop;
	step_t n_intr;
	step_t n_wreg;
	step_t n_shift;
	reg_addr_t a;
	reg_addr_t b;
	logic run_after;
} case_t;

localparam int n_cases = 12;

// columns: irq, ir, stop, intr_ack count, w_reg count, shift_step count,
// first reg_a, reg_b, run after cycle_end
// an irq row follows a row that leaves run clear, so irq is set before start
localparam case_t cases [n_cases] = '{
	'{1'b0, 16'h1500, 1'b0, 4'd0, 4'd1, 4'd0, 3'd2, 3'd5, 1'b1},
	'{1'b0, 16'h5800, 1'b0, 4'd0, 4'd5, 4'd0, 3'd3, 3'd0, 1'b1},
	'{1'b0, 16'h4000, 1'b0, 4'd0, 4'd8, 4'd0, 3'd0, 3'd0, 1'b1},
	'{1'b0, 16'h7800, 1'b0, 4'd0, 4'd1, 4'd0, 3'd7, 3'd0, 1'b1},
	'{1'b0, 16'h8005, 1'b0, 4'd0, 4'd0, 4'd5, 3'd0, 3'd0, 1'b1},
	'{1'b0, 16'h8000, 1'b0, 4'd0, 4'd0, 4'd0, 3'd0, 3'd0, 1'b1},
	'{1'b0, 16'hc000, 1'b0, 4'd0, 4'd0, 4'd0, 3'd0, 3'd0, 1'b0},
	'{1'b1, 16'h1500, 1'b0, 4'd1, 4'd0, 4'd0, 3'd7, 3'd0, 1'b1},
	'{1'b0, 16'h2e00, 1'b0, 4'd0, 4'd1, 4'd0, 3'd5, 3'd6, 1'b1},
	'{1'b0, 16'h0f00, 1'b1, 4'd0, 4'd1, 4'd0, 3'd1, 3'd7, 1'b0},
	'{1'b0, 16'h800f, 1'b0, 4'd0, 4'd0, 4'd15, 3'd0, 3'd0, 1'b1},
	'{1'b0, 16'h6800, 1'b1, 4'd0, 4'd3, 4'd0, 3'd5, 3'd0, 1'b0}
};

string case_names [n_cases] = '{
	"move r2 r5", "group from 3", "group from 0", "group from 7",
	"shift by 5", "shift by 0", "halt", "interrupt", "move r5 r6",
	"stop during move", "shift by 15", "stop during group"
};

// ==== tests/pm_tb.sv ====
// instruction cycle control testbench
`timescale 1ns/1ps

module pm_tb;
	import pm_pkg::*;

	`include "pm_cases.svh"

	localparam int clk_period = 40;
	localparam int row_cycles = 40;
	localparam int unsigned rnd_seed = 32'h6fa5;

	logic __clk;
	logic arst_n;
	logic start;
	logic stop;
	logic irq;
	word_t ir;
	logic ir_ok;
	logic run;
	logic fetch;
	logic intr_ack;
	logic w_reg;
	reg_addr_t reg_a;
	reg_addr_t reg_b;
	logic shift_step;
	logic cycle_end;

	string cur_name;
	int errors = 0;
	int n_pass = 0;
	int n_fail = 0;

	pm i_pm (
		.__clk(__clk), .arst_n(arst_n), .start(start), .stop(stop), .irq(irq),
		.ir(ir), .ir_ok(ir_ok), .run(run), .fetch(fetch), .intr_ack(intr_ack),
		.w_reg(w_reg), .reg_a(reg_a), .reg_b(reg_b), .shift_step(shift_step),
		.cycle_end(cycle_end)
	);

	always #(clk_period / 2) __clk = ~__clk;

	task automatic check_reg(input string what, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp) begin
			$display("error %s: %s expected %0d actual %0d", cur_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_step(input string what, input step_t exp, input step_t act);
		if (act !== exp) begin
			$display("error %s: %s expected %0d actual %0d", cur_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input bit exp, input bit act);
		if (act !== exp) begin
			$display("error %s: %s expected %0d actual %0d", cur_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input int err_start);
		if (errors == err_start) begin
			n_pass++;
			$display("test %s: pass", cur_name);
		end else begin
			n_fail++;
			$display("test %s: fail", cur_name);
		end
	endtask

	// outputs stay quiet with run clear after reset
	task automatic check_reset_idle();
		int err_start;
		err_start = errors;
		cur_name = "reset idle";
		repeat (4) begin
			@(negedge __clk);
			check_flag("run", 1'b0, run);
			check_flag("fetch", 1'b0, fetch);
			check_flag("intr_ack", 1'b0, intr_ack);
			check_flag("w_reg", 1'b0, w_reg);
			check_flag("shift_step", 1'b0, shift_step);
			check_flag("cycle_end", 1'b0, cycle_end);
		end
		report_test(err_start);
	endtask

	// one instruction cycle, from start or cycle start up to cycle_end
	task automatic run_case(input int i);
		case_t c;
		int err_start;
		int n_intr;
		int n_wr;
		int n_sh;
		int ir_wait;
		bit fetch_seen;
		bit stop_sent;
		bit done;
		c = cases[i];
		cur_name = case_names[i];
		err_start = errors;
		n_intr = 0;
		n_wr = 0;
		n_sh = 0;
		ir_wait = -1;
		fetch_seen = 1'b0;
		stop_sent = 1'b0;
		done = 1'b0;
		if (!run) begin
			// stopped unit must not fetch on its own
			repeat (4) begin
				@(negedge __clk);
				check_flag("fetch while stopped", 1'b0, fetch);
			end
			@(posedge __clk);
			start <= 1'b1;
			ir <= c.ir;
			irq <= c.irq;
			@(posedge __clk);
			start <= 1'b0;
			@(negedge __clk);
			check_flag("run after start", 1'b1, run);
		end else begin
			@(posedge __clk);
			ir <= c.ir;
			irq <= c.irq;
		end
		while (!done) begin
			@(negedge __clk);
			if (fetch) begin
				fetch_seen = 1'b1;
				ir_wait = $urandom % 6;
			end
			if (intr_ack) begin
				n_intr++;
				check_reg("reg_a on intr_ack", c.a, reg_a);
			end
			if (w_reg) begin
				// group transfers walk reg_a upward by one per pulse
				check_reg("reg_a on w_reg", c.a + reg_addr_t'(n_wr), reg_a);
				check_reg("reg_b on w_reg", c.b, reg_b);
				n_wr++;
			end
			if (shift_step) begin
				n_sh++;
			end
			done = cycle_end;
			if (!done) begin
				@(posedge __clk);
				// memory answers the fetch after a random delay
				ir_ok <= (ir_wait == 0);
				if (ir_wait >= 0) begin
					ir_wait = ir_wait - 1;
				end
				if (c.stop && fetch_seen && !stop_sent) begin
					stop <= 1'b1;
					stop_sent = 1'b1;
				end else begin
					stop <= 1'b0;
				end
				if (n_intr > 0) begin
					irq <= 1'b0;
				end
			end
		end
		@(posedge __clk);
		@(negedge __clk);
		check_step("intr_ack count", c.n_intr, step_t'(n_intr));
		check_step("w_reg count", c.n_wreg, step_t'(n_wr));
		check_step("shift_step count", c.n_shift, step_t'(n_sh));
		check_flag("fetch seen", !c.irq, fetch_seen);
		check_flag("run after cycle_end", c.run_after, run);
		report_test(err_start);
	endtask

	// watchdog
	initial begin
		#((n_cases + 1) * row_cycles * clk_period);
		$display("timeout: the tests did not finish in the allowed time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		__clk = 1'b0;
		arst_n = 1'b0;
		start = 1'b0;
		stop = 1'b0;
		irq = 1'b0;
		ir = '0;
		ir_ok = 1'b0;
		void'($urandom(rnd_seed));
		repeat (3) @(posedge __clk);
		arst_n <= 1'b1;
		check_reset_idle();
		for (int i = 0; i < n_cases; i++) begin
			run_case(i);
		end
		$display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
